/* hdl/csr_pkg.sv */
package csr_pkg;
    localparam int XLEN = 32;  // Data width

    typedef enum logic [1:0] {
        PRIV_U = 2'd0,
        PRIV_S = 2'd1,
        PRIV_M = 2'd3
    } priv_mode_t;

    // Codes 4 and up are the trap class
    typedef enum logic [2:0] {
        CSR_X     = 3'd0,  // No CSR operation
        CSR_W     = 3'd1,
        CSR_S     = 3'd2,  // Set bits
        CSR_C     = 3'd3,  // Clear bits
        CSR_ECALL = 3'd4,
        CSR_MRET  = 3'd5,
        CSR_SRET  = 3'd6
    } csr_cmd_t;

    typedef enum logic [11:0] {
        ADDR_SSTATUS  = 12'h100,
        ADDR_SIE      = 12'h104,
        ADDR_STVEC    = 12'h105,
        ADDR_SSCRATCH = 12'h140,
        ADDR_SEPC     = 12'h141,
        ADDR_SCAUSE   = 12'h142,
        ADDR_SIP      = 12'h144,
        ADDR_MSTATUS  = 12'h300,
        ADDR_MEDELEG  = 12'h302,
        ADDR_MIDELEG  = 12'h303,
        ADDR_MIE      = 12'h304,
        ADDR_MTVEC    = 12'h305,
        ADDR_MSCRATCH = 12'h340,
        ADDR_MEPC     = 12'h341,
        ADDR_MCAUSE   = 12'h342,
        ADDR_MIP      = 12'h344,
        ADDR_MCYCLE   = 12'hb00,
        ADDR_MCYCLEH  = 12'hb80,
        ADDR_CYCLE    = 12'hc00,  // User read-only view
        ADDR_CYCLEH   = 12'hc80
    } csr_addr_t;

    typedef enum logic [1:0] {
        TVEC_DIRECT   = 2'd0,
        TVEC_VECTORED = 2'd1  // Base plus four times the cause code
    } tvec_mode_t;

    localparam logic [XLEN-1:0] CAUSE_ECALL_U = 32'd8;
    localparam logic [XLEN-1:0] CAUSE_ECALL_S = 32'd9;
    localparam logic [XLEN-1:0] CAUSE_ECALL_M = 32'd11;
    localparam logic [XLEN-1:0] CAUSE_SSI     = 32'h8000_0001;  // Interrupts have bit 31 set
    localparam logic [XLEN-1:0] CAUSE_STI     = 32'h8000_0005;
    localparam logic [XLEN-1:0] CAUSE_MTI     = 32'h8000_0007;
    localparam logic [XLEN-1:0] CAUSE_SEI     = 32'h8000_0009;

    // mstatus field positions
    localparam int ST_SIE  = 1;
    localparam int ST_MIE  = 3;
    localparam int ST_SPIE = 5;
    localparam int ST_MPIE = 7;
    localparam int ST_SPP  = 8;
    localparam int ST_MPP  = 11;  // Low bit of the two-bit field

    // Bit positions in mie/mip
    localparam int IRQ_SSI = 1;
    localparam int IRQ_STI = 5;
    localparam int IRQ_MTI = 7;
    localparam int IRQ_SEI = 9;
endpackage

/* hdl/csr_access_if.sv */
interface csr_access_if import csr_pkg::*; ();
    logic [11:0]     addr;       // Raw CSR address
    priv_mode_t      mode;       // Current privilege
    logic            we;
    logic [XLEN-1:0] wdata;
    logic [XLEN-1:0] rdata_raw;  // Old value before privilege gating

    // Access checker side
    modport master (
        output addr, we, wdata,
        input  mode, rdata_raw
    );

    // Register file side
    modport slave (
        input  addr, we, wdata,
        output mode, rdata_raw
    );
endinterface

/* hdl/csr_trap_if.sv */
interface csr_trap_if import csr_pkg::*; ();
    // State from the register file
    priv_mode_t      mode;
    logic            mstatus_mie;
    logic            mstatus_sie;
    logic [XLEN-1:0] mie;
    logic [XLEN-1:0] mip;
    logic [XLEN-1:0] mideleg;
    logic [XLEN-1:0] medeleg;
    logic [XLEN-1:0] mtvec;
    logic [XLEN-1:0] stvec;
    logic [XLEN-1:0] mepc;
    logic [XLEN-1:0] sepc;
    // Arbiter result
    logic            irq_pending;
    logic [XLEN-1:0] irq_cause;
    logic            irq_to_m;
    // Commands from trap control
    logic            take_trap;    // High through both cycles of a stalled instruction
    logic            trap_to_m;
    logic [XLEN-1:0] trap_cause;
    logic            do_mret;
    logic            do_sret;
    logic            first_cycle;

    modport regfile (
        output mode, mstatus_mie, mstatus_sie, mie, mip, mideleg, medeleg,
        output mtvec, stvec, mepc, sepc,
        input  take_trap, trap_to_m, trap_cause, do_mret, do_sret, first_cycle
    );
    modport arbiter (
        input  mode, mstatus_mie, mstatus_sie, mie, mip, mideleg,
        output irq_pending, irq_cause, irq_to_m
    );
    modport control (
        input  mode, medeleg, mtvec, stvec, mepc, sepc, irq_pending, irq_cause, irq_to_m,
        output take_trap, trap_to_m, trap_cause, do_mret, do_sret, first_cycle
    );
endinterface

/* hdl/csr_access.sv */
module csr_access import csr_pkg::*; (
    input  logic            csr_valid,
    input  csr_cmd_t        csr_cmd,
    input  logic [11:0]     csr_addr,
    input  logic [XLEN-1:0] csr_op1,
    input  logic            take_trap,
    csr_access_if.master    acc,
    output logic [XLEN-1:0] csr_rdata
);
    logic can_acc;
    logic can_wr;
    logic is_rmw;

    assign acc.addr = csr_addr;

    // Bits 9:8 give the lowest mode allowed
    assign can_acc = csr_addr[9:8] <= acc.mode;
    assign can_wr  = can_acc && (csr_addr[11:10] != 2'b11);  // 11 marks read-only space
    assign is_rmw  = csr_cmd inside {CSR_W, CSR_S, CSR_C};

    // New value built from the old one
    always_comb begin
        case (csr_cmd)
            CSR_W:   acc.wdata = csr_op1;
            CSR_S:   acc.wdata = acc.rdata_raw | csr_op1;
            CSR_C:   acc.wdata = acc.rdata_raw & ~csr_op1;
            default: acc.wdata = '0;
        endcase
    end

    // No write from an instruction that traps
    assign acc.we = csr_valid && is_rmw && can_wr && !take_trap;

    assign csr_rdata = can_acc ? acc.rdata_raw : '0;  // Denied reads return zero
endmodule

/* hdl/csr_regfile.sv */
module csr_regfile import csr_pkg::*; (
    input  logic            clk,
    input  logic            rst_n,
    input  logic [XLEN-1:0] csr_pc,
    input  logic [63:0]     cycle,
    input  logic [63:0]     mtime,
    input  logic [63:0]     mtimecmp,
    csr_access_if.slave     acc,
    csr_trap_if.regfile     trp
);
    // Software-writable pending bits SSIP, STIP and SEIP
    localparam logic [XLEN-1:0] S_IRQ = (XLEN'(1) << IRQ_SSI) | (XLEN'(1) << IRQ_STI)
                                      | (XLEN'(1) << IRQ_SEI);
    localparam logic [XLEN-1:0] M_IRQ = S_IRQ | (XLEN'(1) << IRQ_MTI);
    localparam logic [XLEN-1:0] SSTATUS_MASK = (XLEN'(1) << ST_SPP) | (XLEN'(1) << ST_SPIE)
                                             | (XLEN'(1) << ST_SIE);

    priv_mode_t      mode;
    logic [1:0]      mpp;
    logic            spp;
    logic            mpie;
    logic            spie;
    logic            st_mie;    // mstatus.MIE
    logic            st_sie;    // mstatus.SIE
    logic            mtip;
    logic [XLEN-1:0] ip_sw;     // SEIP, STIP, SSIP
    logic [XLEN-1:0] mie;
    logic [XLEN-1:0] mideleg;
    logic [XLEN-1:0] medeleg;
    logic [XLEN-1:0] mtvec;
    logic [XLEN-1:0] stvec;
    logic [XLEN-1:0] mscratch;
    logic [XLEN-1:0] sscratch;
    logic [XLEN-1:0] mepc;
    logic [XLEN-1:0] sepc;
    logic [XLEN-1:0] mcause;
    logic [XLEN-1:0] scause;
    logic [XLEN-1:0] mstatus_v;
    logic [XLEN-1:0] mip_v;

    always_comb begin
        mstatus_v = '0;
        mstatus_v[ST_MPP +: 2] = mpp;
        mstatus_v[ST_SPP]      = spp;
        mstatus_v[ST_MPIE]     = mpie;
        mstatus_v[ST_SPIE]     = spie;
        mstatus_v[ST_MIE]      = st_mie;
        mstatus_v[ST_SIE]      = st_sie;
    end
    assign mip_v = ip_sw | (XLEN'(mtip) << IRQ_MTI);

    // Read mux with masked sstatus, sie and sip views
    always_comb begin
        case (csr_addr_t'(acc.addr))
            ADDR_MSTATUS:              acc.rdata_raw = mstatus_v;
            ADDR_SSTATUS:              acc.rdata_raw = mstatus_v & SSTATUS_MASK;
            ADDR_MEDELEG:              acc.rdata_raw = medeleg;
            ADDR_MIDELEG:              acc.rdata_raw = mideleg;
            ADDR_MIE:                  acc.rdata_raw = mie;
            ADDR_SIE:                  acc.rdata_raw = mie & S_IRQ;
            ADDR_MIP:                  acc.rdata_raw = mip_v;
            ADDR_SIP:                  acc.rdata_raw = mip_v & S_IRQ;
            ADDR_MTVEC:                acc.rdata_raw = mtvec;
            ADDR_STVEC:                acc.rdata_raw = stvec;
            ADDR_MSCRATCH:             acc.rdata_raw = mscratch;
            ADDR_SSCRATCH:             acc.rdata_raw = sscratch;
            ADDR_MEPC:                 acc.rdata_raw = mepc;
            ADDR_SEPC:                 acc.rdata_raw = sepc;
            ADDR_MCAUSE:               acc.rdata_raw = mcause;
            ADDR_SCAUSE:               acc.rdata_raw = scause;
            ADDR_CYCLE, ADDR_MCYCLE:   acc.rdata_raw = cycle[31:0];
            ADDR_CYCLEH, ADDR_MCYCLEH: acc.rdata_raw = cycle[63:32];
            default:                   acc.rdata_raw = '0;
        endcase
    end

    assign acc.mode        = mode;
    assign trp.mode        = mode;
    assign trp.mstatus_mie = st_mie;
    assign trp.mstatus_sie = st_sie;
    assign trp.mie         = mie;
    assign trp.mip         = mip_v;
    assign trp.mideleg     = mideleg;
    assign trp.medeleg     = medeleg;
    assign trp.mtvec       = mtvec;
    assign trp.stvec       = stvec;
    assign trp.mepc        = mepc;
    assign trp.sepc        = sepc;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mode     <= PRIV_M;
            mpp      <= PRIV_M;
            spp      <= 1'b0;
            mpie     <= 1'b0;
            spie     <= 1'b0;
            st_mie   <= 1'b0;
            st_sie   <= 1'b0;
            mtip     <= 1'b0;
            ip_sw    <= '0;
            mie      <= '0;
            mideleg  <= '0;
            medeleg  <= '0;
            mtvec    <= '0;
            stvec    <= '0;
            mscratch <= '0;
            sscratch <= '0;
            mepc     <= '0;
            sepc     <= '0;
            mcause   <= '0;
            scause   <= '0;
        end else if (trp.take_trap && trp.first_cycle) begin
            // Trap entry pushes the enable and mode stack
            if (trp.trap_to_m) begin
                mode   <= PRIV_M;
                mcause <= trp.trap_cause;
                mepc   <= csr_pc;
                mpie   <= st_mie;
                st_mie <= 1'b0;
                mpp    <= mode;
            end else begin
                mode   <= PRIV_S;
                scause <= trp.trap_cause;
                sepc   <= csr_pc;
                spie   <= st_sie;
                st_sie <= 1'b0;
                spp    <= mode[0];  // Only U or S can trap to S
            end
        end else begin
            if (trp.first_cycle)
                mtip <= mtime >= mtimecmp;  // Timer compare sampled once per instruction
            if (trp.do_mret) begin
                st_mie <= mpie;
                mode   <= priv_mode_t'(mpp);
                mpie   <= 1'b1;
                mpp    <= PRIV_U;
            end
            if (trp.do_sret) begin
                st_sie <= spie;
                mode   <= spp ? PRIV_S : PRIV_U;
                spie   <= 1'b1;
                spp    <= 1'b0;
            end
            if (acc.we) begin
                case (csr_addr_t'(acc.addr))
                    ADDR_MSTATUS: begin
                        if (acc.wdata[ST_MPP +: 2] != 2'b10)  // Reserved encoding keeps old MPP
                            mpp <= acc.wdata[ST_MPP +: 2];
                        spp    <= acc.wdata[ST_SPP];
                        mpie   <= acc.wdata[ST_MPIE];
                        spie   <= acc.wdata[ST_SPIE];
                        st_mie <= acc.wdata[ST_MIE];
                        st_sie <= acc.wdata[ST_SIE];
                    end
                    ADDR_SSTATUS: begin
                        spp    <= acc.wdata[ST_SPP];
                        spie   <= acc.wdata[ST_SPIE];
                        st_sie <= acc.wdata[ST_SIE];
                    end
                    ADDR_MEDELEG:       medeleg  <= acc.wdata;
                    ADDR_MIDELEG:       mideleg  <= acc.wdata & M_IRQ;
                    ADDR_MIE:           mie      <= acc.wdata & M_IRQ;
                    ADDR_SIE:           mie      <= (mie & ~S_IRQ) | (acc.wdata & S_IRQ);
                    ADDR_MIP, ADDR_SIP: ip_sw    <= acc.wdata & S_IRQ;
                    ADDR_MTVEC:         mtvec    <= acc.wdata;
                    ADDR_STVEC:         stvec    <= acc.wdata;
                    ADDR_MSCRATCH:      mscratch <= acc.wdata;
                    ADDR_SSCRATCH:      sscratch <= acc.wdata;
                    ADDR_MEPC:          mepc     <= {acc.wdata[XLEN-1:2], 2'b00};
                    ADDR_SEPC:          sepc     <= acc.wdata;
                    ADDR_MCAUSE:        mcause   <= acc.wdata;
                    ADDR_SCAUSE:        scause   <= acc.wdata;
                    default: ;  // Counters are read-only
                endcase
            end
        end
    end
endmodule

/* hdl/irq_arbiter.sv */
module irq_arbiter import csr_pkg::*; (
    csr_trap_if.arbiter trp
);
    logic [XLEN-1:0] active;  // Pending and enabled
    logic            to_m;
    logic            glb_en;

    assign active = trp.mip & trp.mie;

    // Fixed priority, highest first
    always_comb begin
        if (active[IRQ_MTI])
            trp.irq_cause = CAUSE_MTI;
        else if (active[IRQ_SEI])
            trp.irq_cause = CAUSE_SEI;
        else if (active[IRQ_SSI])
            trp.irq_cause = CAUSE_SSI;
        else if (active[IRQ_STI])
            trp.irq_cause = CAUSE_STI;
        else
            trp.irq_cause = '0;
    end

    // M-mode never delegates down
    assign to_m = (trp.mode == PRIV_M) || !trp.mideleg[trp.irq_cause[4:0]];

    // Lower modes are always interruptible by a higher target
    assign glb_en = to_m ? ((trp.mode != PRIV_M) || trp.mstatus_mie)
                         : ((trp.mode == PRIV_U) || ((trp.mode == PRIV_S) && trp.mstatus_sie));

    assign trp.irq_pending = (active != '0) && glb_en;
    assign trp.irq_to_m    = to_m;
endmodule

/* hdl/trap_ctrl.sv */
module trap_ctrl import csr_pkg::*; #(
    parameter int INST_ID_W = 8
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 csr_valid,
    input  logic [INST_ID_W-1:0] csr_inst_id,
    input  csr_cmd_t             csr_cmd,
    csr_trap_if.control          trp,
    output logic                 stall_flg,
    output logic                 trap_flg,
    output logic [XLEN-1:0]      trap_vector
);
    logic [INST_ID_W-1:0] saved_id;   // Id of the last valid cycle
    logic                 pend;       // Trap or return applied last cycle
    logic                 is_ecall;
    logic                 trap_req;
    logic [XLEN-1:0]      exc_cause;
    logic [XLEN-1:0]      tvec;
    logic [XLEN-1:0]      tvec_base;

    // New id means a new instruction
    assign trp.first_cycle = csr_valid && (csr_inst_id != saved_id);
    assign is_ecall        = csr_cmd == CSR_ECALL;
    assign trap_req        = is_ecall || trp.irq_pending;

    always_comb begin
        case (trp.mode)
            PRIV_U:  exc_cause = CAUSE_ECALL_U;
            PRIV_S:  exc_cause = CAUSE_ECALL_S;
            default: exc_cause = CAUSE_ECALL_M;
        endcase
    end

    // Decided on the first cycle, held through the second
    assign trp.take_trap  = csr_valid && (trp.first_cycle ? trap_req : pend);
    assign trp.trap_to_m  = is_ecall ? ((trp.mode == PRIV_M) || !trp.medeleg[exc_cause[4:0]])
                                     : trp.irq_to_m;
    assign trp.trap_cause = is_ecall ? exc_cause : trp.irq_cause;  // ECALL wins over interrupts
    assign trp.do_mret    = trp.first_cycle && !trap_req && (csr_cmd == CSR_MRET);
    assign trp.do_sret    = trp.first_cycle && !trap_req && (csr_cmd == CSR_SRET);

    assign stall_flg = trp.first_cycle && (csr_cmd[2] || trp.irq_pending);
    assign trap_flg  = csr_valid && pend;

    assign tvec      = trp.trap_to_m ? trp.mtvec : trp.stvec;
    assign tvec_base = {tvec[XLEN-1:2], 2'b00};

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            saved_id <= '0;
            pend     <= 1'b0;
        end else begin
            if (csr_valid)
                saved_id <= csr_inst_id;
            pend <= stall_flg;  // Clears after one cycle
        end
    end

    // Target address, valid in the cycle after the stall
    always_ff @(posedge clk) begin
        if (trp.first_cycle && trap_req) begin
            if (!is_ecall && (tvec_mode_t'(tvec[1:0]) == TVEC_VECTORED))
                trap_vector <= tvec_base + {trp.irq_cause[XLEN-3:0], 2'b00};
            else
                trap_vector <= tvec_base;  // Exceptions always use the base
        end else if (trp.do_mret) begin
            trap_vector <= trp.mepc;
        end else if (trp.do_sret) begin
            trap_vector <= trp.sepc;
        end
    end
endmodule

/* hdl/csr_stage.sv */
module csr_stage import csr_pkg::*; #(
    parameter int INST_ID_W = 8
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 csr_valid,
    input  logic [XLEN-1:0]      csr_pc,
    input  logic [INST_ID_W-1:0] csr_inst_id,
    input  csr_cmd_t             csr_cmd,
    input  logic [11:0]          csr_addr,
    input  logic [XLEN-1:0]      csr_op1,
    input  logic [63:0]          cycle,
    input  logic [63:0]          mtime,
    input  logic [63:0]          mtimecmp,
    output logic [XLEN-1:0]      csr_rdata,
    output logic                 stall_flg,
    output logic                 trap_flg,
    output logic [XLEN-1:0]      trap_vector
);
    csr_access_if acc_if ();
    csr_trap_if   trp_if ();

    csr_access u_access (
        .csr_valid (csr_valid),
        .csr_cmd   (csr_cmd),
        .csr_addr  (csr_addr),
        .csr_op1   (csr_op1),
        .take_trap (trp_if.take_trap),  // Blocks the write of a trapping instruction
        .acc       (acc_if.master),
        .csr_rdata (csr_rdata)
    );

    csr_regfile u_regfile (
        .clk      (clk),
        .rst_n    (rst_n),
        .csr_pc   (csr_pc),
        .cycle    (cycle),
        .mtime    (mtime),
        .mtimecmp (mtimecmp),
        .acc      (acc_if.slave),
        .trp      (trp_if.regfile)
    );

    irq_arbiter u_arbiter (
        .trp (trp_if.arbiter)
    );

    trap_ctrl #(
        .INST_ID_W (INST_ID_W)
    ) u_trap (
        .clk         (clk),
        .rst_n       (rst_n),
        .csr_valid   (csr_valid),
        .csr_inst_id (csr_inst_id),
        .csr_cmd     (csr_cmd),
        .trp         (trp_if.control),
        .stall_flg   (stall_flg),
        .trap_flg    (trap_flg),
        .trap_vector (trap_vector)
    );
endmodule

/* tb/tb_csr_stage.sv */
module tb_csr_stage import csr_pkg::*; ();
    // Roughly 70 instructions of at most two cycles each, plus reset, with wide margin
    localparam int MAX_CYCLES = 2000;

    logic            clk = 1'b0;
    logic            rst_n;
    logic            csr_valid;
    logic [XLEN-1:0] csr_pc;
    logic [7:0]      csr_inst_id;
    csr_cmd_t        csr_cmd;
    logic [11:0]     csr_addr;
    logic [XLEN-1:0] csr_op1;
    logic [63:0]     cycle;
    logic [63:0]     mtime;
    logic [63:0]     mtimecmp;
    logic [XLEN-1:0] csr_rdata;
    logic            stall_flg;
    logic            trap_flg;
    logic [XLEN-1:0] trap_vector;

    // Seen during the last instruction
    logic [XLEN-1:0] rd;          // Read data of the first cycle
    logic            stalled;
    logic            early_trap;  // trap_flg while still stalled
    logic            trapped;
    logic [XLEN-1:0] vec;
    int              stall_cycles;

    // Reference model state
    logic [XLEN-1:0] m_scratch;
    logic [XLEN-1:0] m_mtvec;
    logic [XLEN-1:0] m_stvec;
    logic [XLEN-1:0] m_epc;
    logic [XLEN-1:0] r;
    logic [XLEN-1:0] trap_pc;     // pc of the instruction that trapped

    integer seed = 32'h41792c1a;
    int     cycles = 0;
    int     checks = 0;
    int     errors = 0;
    int     test_no = 0;
    int     errors_before = 0;
    int     tests_failed = 0;

    csr_stage #(
        .INST_ID_W (8)
    ) UUT (
        .clk         (clk),
        .rst_n       (rst_n),
        .csr_valid   (csr_valid),
        .csr_pc      (csr_pc),
        .csr_inst_id (csr_inst_id),
        .csr_cmd     (csr_cmd),
        .csr_addr    (csr_addr),
        .csr_op1     (csr_op1),
        .cycle       (cycle),
        .mtime       (mtime),
        .mtimecmp    (mtimecmp),
        .csr_rdata   (csr_rdata),
        .stall_flg   (stall_flg),
        .trap_flg    (trap_flg),
        .trap_vector (trap_vector)
    );

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout after %0d cycles, the test sequence did not finish", cycles);
            $display("Testbench failed");
            $finish;
        end
    end

    task automatic check_val(input string name, input logic [XLEN-1:0] got,
                             input logic [XLEN-1:0] exp);
        checks++;
        assert (got === exp)
        else begin
            errors++;
            $display("MISMATCH %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        checks++;
        assert (got === exp)
        else begin
            errors++;
            $display("MISMATCH %s: got %h, expected %h", name, got, exp);
        end
    endtask

    // One instruction, held while stalled, new id each time
    task automatic run_inst(input csr_cmd_t cmd, input logic [11:0] addr,
                            input logic [XLEN-1:0] op1);
        csr_inst_id  = csr_inst_id + 8'd1;
        csr_pc       = 32'h0000_1000 + (32'(csr_inst_id) << 2);
        csr_valid    = 1'b1;
        csr_cmd      = cmd;
        csr_addr     = addr;
        csr_op1      = op1;
        stall_cycles = 0;
        early_trap   = 1'b0;
        @(negedge clk);
        rd      = csr_rdata;  // Old register value
        stalled = stall_flg;
        while (stall_flg) begin
            early_trap = early_trap | trap_flg;
            stall_cycles++;
            if (stall_cycles > 4) begin
                errors++;
                $display("Stall did not release for instruction id %0d", csr_inst_id);
                break;
            end
            @(posedge clk);
            #1;
            @(negedge clk);
        end
        trapped = trap_flg;
        vec     = trap_vector;
        @(posedge clk);
        #1;
        csr_valid = 1'b0;
        csr_cmd   = CSR_X;
    endtask

    task automatic read_csr(input logic [11:0] addr, input logic [XLEN-1:0] exp,
                            input string name);
        run_inst(CSR_X, addr, '0);
        check_bit("stall_flg", stalled, 1'b0);
        check_val(name, rd, exp);
    endtask

    task automatic write_csr(input logic [11:0] addr, input logic [XLEN-1:0] val);
        run_inst(CSR_W, addr, val);
        check_bit("stall_flg", stalled, 1'b0);
    endtask

    // Stall for one cycle, then trap_flg with the target
    task automatic expect_trap(input logic [XLEN-1:0] exp_vec);
        check_bit("stall_flg", stalled, 1'b1);
        check_val("stall_flg cycles", 32'(stall_cycles), 32'd1);
        check_bit("trap_flg in stall cycle", early_trap, 1'b0);
        check_bit("trap_flg", trapped, 1'b1);
        check_val("trap_vector", vec, exp_vec);
    endtask

    task automatic end_test(input string name);
        test_no++;
        if (errors == errors_before) begin
            $display("test %0d %s: ok", test_no, name);
        end else begin
            tests_failed++;
            $display("test %0d %s: FAILED, %0d errors", test_no, name, errors - errors_before);
        end
        errors_before = errors;
    endtask

    initial begin
        rst_n       = 1'b0;
        csr_valid   = 1'b0;
        csr_pc      = '0;
        csr_inst_id = '0;
        csr_cmd     = CSR_X;
        csr_addr    = '0;
        csr_op1     = '0;
        cycle       = {$random(seed), $random(seed)};
        mtime       = '0;
        mtimecmp    = '1;  // Timer far away
        m_scratch   = '0;
        m_mtvec     = '0;
        m_stvec     = '0;
        m_epc       = '0;
        trap_pc     = '0;
        repeat (8) @(posedge clk);
        #1;
        rst_n = 1'b1;

        // Each access returns the value before the update
        r = $random(seed);
        run_inst(CSR_W, ADDR_MSCRATCH, r);
        check_val("csr_rdata mscratch", rd, m_scratch);
        m_scratch = r;
        r = $random(seed);
        run_inst(CSR_S, ADDR_MSCRATCH, r);
        check_val("csr_rdata mscratch", rd, m_scratch);
        m_scratch = m_scratch | r;
        r = $random(seed);
        run_inst(CSR_C, ADDR_MSCRATCH, r);
        check_val("csr_rdata mscratch", rd, m_scratch);
        m_scratch = m_scratch & ~r;
        read_csr(ADDR_MSCRATCH, m_scratch, "csr_rdata mscratch");
        read_csr(ADDR_CYCLE, cycle[31:0], "csr_rdata cycle");
        read_csr(ADDR_CYCLEH, cycle[63:32], "csr_rdata cycleh");
        read_csr(ADDR_MCYCLE, cycle[31:0], "csr_rdata mcycle");
        read_csr(ADDR_MCYCLEH, cycle[63:32], "csr_rdata mcycleh");
        run_inst(CSR_W, ADDR_CYCLE, ~cycle[31:0]);  // Read-only space
        check_val("csr_rdata cycle", rd, cycle[31:0]);
        read_csr(ADDR_CYCLE, cycle[31:0], "csr_rdata cycle");
        end_test("mscratch and cycle");

        m_mtvec = 32'h0000_0100;  // Direct
        write_csr(ADDR_MTVEC, m_mtvec);
        write_csr(ADDR_MSTATUS, 32'd1 << ST_MIE);  // MPP at U before the trap
        run_inst(CSR_ECALL, 12'h000, '0);
        trap_pc = csr_pc;
        expect_trap(m_mtvec);
        read_csr(ADDR_MCAUSE, CAUSE_ECALL_M, "csr_rdata mcause");
        read_csr(ADDR_MEPC, trap_pc, "csr_rdata mepc");
        // MPIE takes the old MIE and MPP becomes M
        read_csr(ADDR_MSTATUS, (32'd3 << ST_MPP) | (32'd1 << ST_MPIE), "csr_rdata mstatus");
        end_test("ECALL in M");

        write_csr(ADDR_MSTATUS, '0);  // MPP = U
        r = $random(seed);
        m_epc = {r[XLEN-1:2], 2'b00};  // Low bits dropped
        write_csr(ADDR_MEPC, r);
        read_csr(ADDR_MEPC, m_epc, "csr_rdata mepc");
        run_inst(CSR_MRET, 12'h000, '0);
        expect_trap(m_epc);
        read_csr(ADDR_MSCRATCH, '0, "csr_rdata mscratch in U");
        run_inst(CSR_W, ADDR_MSCRATCH, ~m_scratch);
        check_bit("stall_flg", stalled, 1'b0);
        check_val("csr_rdata mscratch in U", rd, '0);
        run_inst(CSR_ECALL, 12'h000, '0);  // No delegation yet, so back to M
        trap_pc = csr_pc;
        expect_trap(m_mtvec);
        read_csr(ADDR_MCAUSE, CAUSE_ECALL_U, "csr_rdata mcause");
        read_csr(ADDR_MSCRATCH, m_scratch, "csr_rdata mscratch");
        end_test("MRET to U");

        read_csr(ADDR_MEPC, trap_pc, "csr_rdata mepc");  // pc of the ECALL from U
        m_stvec = 32'h0000_0400;
        write_csr(ADDR_MEDELEG, 32'd1 << 8);  // ECALL from U goes to S
        write_csr(ADDR_STVEC, m_stvec);
        write_csr(ADDR_MSTATUS, '0);
        run_inst(CSR_MRET, 12'h000, '0);
        expect_trap(trap_pc);
        run_inst(CSR_ECALL, 12'h000, '0);
        trap_pc = csr_pc;
        expect_trap(m_stvec);
        read_csr(ADDR_SCAUSE, CAUSE_ECALL_U, "csr_rdata scause");
        read_csr(ADDR_SEPC, trap_pc, "csr_rdata sepc");
        run_inst(CSR_SRET, 12'h000, '0);
        expect_trap(trap_pc);
        // U to S, then S to M since ECALL from S is not delegated
        run_inst(CSR_ECALL, 12'h000, '0);
        expect_trap(m_stvec);
        run_inst(CSR_ECALL, 12'h000, '0);
        expect_trap(m_mtvec);
        read_csr(ADDR_MCAUSE, CAUSE_ECALL_S, "csr_rdata mcause");
        end_test("ECALL delegated to S");

        m_mtvec = 32'h0000_0801;  // Vectored
        write_csr(ADDR_MTVEC, m_mtvec);
        write_csr(ADDR_MIE, 32'd1 << IRQ_MTI);
        write_csr(ADDR_MSTATUS, (32'd3 << ST_MPP) | (32'd1 << ST_MIE));
        mtime    = 64'd50;
        mtimecmp = 64'd50;  // Equal counts as expired
        read_csr(ADDR_MIP, '0, "csr_rdata mip");  // Samples MTIP
        r = $random(seed);
        run_inst(CSR_W, ADDR_MSCRATCH, r);
        trap_pc = csr_pc;
        expect_trap({m_mtvec[XLEN-1:2], 2'b00} + 32'd28);  // 4 times cause code 7
        read_csr(ADDR_MCAUSE, CAUSE_MTI, "csr_rdata mcause");
        read_csr(ADDR_MEPC, trap_pc, "csr_rdata mepc");
        read_csr(ADDR_MSCRATCH, m_scratch, "csr_rdata mscratch");  // Trapped write dropped
        read_csr(ADDR_MIP, 32'd1 << IRQ_MTI, "csr_rdata mip");
        mtimecmp = '1;
        write_csr(ADDR_MIE, '0);
        end_test("timer interrupt");

        m_stvec = 32'h0000_0600;
        write_csr(ADDR_STVEC, m_stvec);
        write_csr(ADDR_MIDELEG, 32'd1 << IRQ_SSI);
        write_csr(ADDR_MIE, 32'd1 << IRQ_SSI);
        write_csr(ADDR_MIP, 32'd1 << IRQ_SSI);  // Held off while in M
        write_csr(ADDR_MSTATUS, '0);
        run_inst(CSR_MRET, 12'h000, '0);
        expect_trap(trap_pc);  // mepc of the timer trap
        run_inst(CSR_X, ADDR_SSCRATCH, '0);
        trap_pc = csr_pc;
        expect_trap(m_stvec);
        read_csr(ADDR_SCAUSE, CAUSE_SSI, "csr_rdata scause");
        read_csr(ADDR_SEPC, trap_pc, "csr_rdata sepc");
        read_csr(ADDR_SIP, 32'd1 << IRQ_SSI, "csr_rdata sip");
        end_test("software interrupt to S");

        $display("tests: %0d run, %0d failed; checks: %0d, errors: %0d",
                 test_no, tests_failed, checks, errors);
        if (errors == 0)
            $display("Testbench passed");
        else
            $display("Testbench failed");
        $finish;
    end
endmodule

/* compile.f */
hdl/csr_pkg.sv
hdl/csr_access_if.sv
hdl/csr_trap_if.sv
hdl/csr_access.sv
hdl/csr_regfile.sv
hdl/irq_arbiter.sv
hdl/trap_ctrl.sv
hdl/csr_stage.sv
tb/tb_csr_stage.sv

/* Makefile */
VERILATOR  ?= verilator
FLAGS      = --binary --timing --assert -j 0
LINT_FLAGS = --lint-only --timing
TOP        = tb_csr_stage
FILELIST   = compile.f
OBJ_DIR    = obj_dir
PASS_MSG   = Testbench passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
